/* logic/ethpipe_pkg.sv */
package ethpipe_pkg;

  // bus and register widths
  typedef logic [15:0] bus_data_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [1:0]  byte_sel_t;
  typedef logic [63:0] gcount_t;
  typedef logic [47:0] tstamp_t;
  typedef logic [19:0] dma_len_t;
  typedef logic [29:0] dma_addr_t;
  typedef logic [13:0] tx_ptr_t;
  typedef logic [31:0] intr_cnt_t;
  typedef logic [7:0]  dma_status_t;

  typedef enum logic [1:0] {st_idle, st_dwell, st_holdoff} intr_state_t;

  localparam int TS_SLOTS        = 2;
  localparam int TS_LATENCY_COMP = 3;
  localparam int STATUS_INTR_BIT = 3;

  localparam intr_cnt_t INTR_VAL_RESET = intr_cnt_t'(2500000);
  localparam dma_len_t  DMA_LEN_RESET  = dma_len_t'(20'h04000);
  localparam dma_addr_t DMA_ADDR_RESET = dma_addr_t'(32'h1000_0000 >> 2);

  // --------------------
  // register map, word addresses
  localparam reg_addr_t ADR_GCNT0        = 8'h02;
  localparam reg_addr_t ADR_GCNT1        = 8'h03;
  localparam reg_addr_t ADR_GCNT2        = 8'h04;
  localparam reg_addr_t ADR_GCNT3        = 8'h05;
  localparam reg_addr_t ADR_STATUS       = 8'h08;
  localparam reg_addr_t ADR_LEN_LO       = 8'h0a;
  localparam reg_addr_t ADR_LEN_HI       = 8'h0b;
  localparam reg_addr_t ADR_DMA_START_LO = 8'h10;
  localparam reg_addr_t ADR_DMA_START_HI = 8'h11;
  localparam reg_addr_t ADR_DMA_CUR_LO   = 8'h12;
  localparam reg_addr_t ADR_DMA_CUR_HI   = 8'h13;
  localparam reg_addr_t ADR_TX_WR_PTR    = 8'h18;
  localparam reg_addr_t ADR_TX_RD_PTR    = 8'h1a;
  localparam reg_addr_t ADR_CLR_VAL_LO   = 8'h40;
  localparam reg_addr_t ADR_CLR_VAL_HI   = 8'h41;
  localparam reg_addr_t ADR_SET_VAL_LO   = 8'h42;
  localparam reg_addr_t ADR_SET_VAL_HI   = 8'h43;
  localparam reg_addr_t ADR_TS_BASE      = 8'h80;

  // bus lanes carry the register bytes swapped
  function automatic bus_data_t lane_swap(bus_data_t w);
    return {w[7:0], w[15:8]};
  endfunction

  function automatic bus_data_t lane_merge(bus_data_t old_w, bus_data_t dat, byte_sel_t sel);
    bus_data_t w;
    w = old_w;
    if (sel[1])
      w[7:0] = dat[15:8];
    if (sel[0])
      w[15:8] = dat[7:0];
    return w;
  endfunction

endpackage

/* logic/intr_timer.sv */
`timescale 1ns/1ps

module intr_timer (
  input  logic                   clk_125,
  input  logic                   sys_rst,
  input  logic                   load_i,
  input  ethpipe_pkg::intr_cnt_t value_i,
  output logic                   zero_o
);
  import ethpipe_pkg::*;

  intr_cnt_t count;

  // down-counter, parks at zero
  always_ff @(posedge clk_125) begin
    if (sys_rst)
      count <= '0;
    else if (load_i)
      count <= value_i;
    else if (count != '0)
      count <= count - intr_cnt_t'(1);
  end

  assign zero_o = (count == '0);

endmodule

/* logic/intr_moderator_fsm.sv */
`timescale 1ns/1ps

module intr_moderator_fsm (
  input  logic                   clk_125,
  input  logic                   sys_rst,
  input  logic                   req_intr_i,
  input  logic                   intr_ack_i,
  input  logic                   tmr_zero_i,
  input  ethpipe_pkg::intr_cnt_t clr_val_i,
  input  ethpipe_pkg::intr_cnt_t set_val_i,
  output logic                   tmr_load_o,
  output ethpipe_pkg::intr_cnt_t tmr_value_o,
  output logic                   intr_active_o
);
  import ethpipe_pkg::*;

  intr_state_t state;
  intr_state_t state_nxt;
  logic        req_q;

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state <= st_idle;
      req_q <= 1'b0;
    end else begin
      state <= state_nxt;
      req_q <= req_intr_i;
    end
  end

  // timer is shared by dwell and holdoff
  always_comb begin
    state_nxt   = state;
    tmr_load_o  = 1'b0;
    tmr_value_o = set_val_i;
    case (state)
      st_idle: begin
        if (req_q) begin
          state_nxt  = st_dwell;
          tmr_load_o = 1'b1;
        end
      end
      st_dwell: begin
        if (intr_ack_i) begin
          state_nxt   = st_holdoff;
          tmr_load_o  = 1'b1;
          tmr_value_o = clr_val_i;
        end else if (tmr_zero_i) begin
          state_nxt = st_idle;
        end
      end
      st_holdoff: begin
        // requests dropped until the timer runs out
        if (tmr_zero_i)
          state_nxt = st_idle;
      end
      default: state_nxt = st_idle;
    endcase
  end

  assign intr_active_o = (state == st_dwell);

endmodule

/* logic/timestamp_unit.sv */
`timescale 1ns/1ps

module timestamp_unit (
  input  logic                                             clk_125,
  input  logic                                             sys_rst,
  input  logic [ethpipe_pkg::TS_SLOTS-1:0]                 time_req_i,
  input  logic [ethpipe_pkg::TS_SLOTS-1:0]                 ts_wr_i,
  input  logic [1:0]                                       ts_word_i,
  input  ethpipe_pkg::byte_sel_t                           slv_sel_i,
  input  ethpipe_pkg::bus_data_t                           slv_dat_i,
  output ethpipe_pkg::gcount_t                             gcount_o,
  output ethpipe_pkg::tstamp_t [ethpipe_pkg::TS_SLOTS-1:0] ts_o
);
  import ethpipe_pkg::*;

  logic [TS_SLOTS-1:0] pending;
  logic [TS_SLOTS-1:0] grant;
  logic [TS_SLOTS-1:0] cap;
  tstamp_t             cap_val;

  // lowest pending slot wins, a host write to it defers the capture
  assign grant   = pending & (~pending + 1'b1);
  assign cap     = grant & ~ts_wr_i;
  assign cap_val = gcount_o[47:0] - tstamp_t'(TS_LATENCY_COMP);

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      gcount_o <= '0;
      pending  <= '0;
      ts_o     <= '0;
    end else begin
      gcount_o <= gcount_o + 64'd1;
      pending  <= (pending & ~cap) | time_req_i;
      for (int n = 0; n < TS_SLOTS; n++) begin
        if (ts_wr_i[n])
          ts_o[n][16 * ts_word_i +: 16] <=
            lane_merge(ts_o[n][16 * ts_word_i +: 16], slv_dat_i, slv_sel_i);
        else if (cap[n])
          ts_o[n] <= cap_val;
      end
    end
  end

endmodule

/* logic/host_regs.sv */
`timescale 1ns/1ps

module host_regs (
  input  logic                                       clk_125,
  input  logic                                       sys_rst,
  input  logic                                       slv_ce_i,
  input  logic                                       slv_we_i,
  input  ethpipe_pkg::reg_addr_t                     slv_adr_i,
  input  ethpipe_pkg::bus_data_t                     slv_dat_i,
  input  ethpipe_pkg::byte_sel_t                     slv_sel_i,
  output ethpipe_pkg::bus_data_t                     slv_dat_o,
  input  ethpipe_pkg::gcount_t                       gcount_i,
  input  ethpipe_pkg::tstamp_t [ethpipe_pkg::TS_SLOTS-1:0] ts_i,
  input  logic                                       intr_active_i,
  input  ethpipe_pkg::dma_addr_t                     dma_addr_cur_i,
  input  ethpipe_pkg::tx_ptr_t                       tx_rd_ptr_i,
  output logic [ethpipe_pkg::TS_SLOTS-1:0]           ts_wr_o,
  output logic [1:0]                                 ts_word_o,
  output logic                                       intr_ack_o,
  output ethpipe_pkg::intr_cnt_t                     clr_val_o,
  output ethpipe_pkg::intr_cnt_t                     set_val_o,
  output logic [7:0]                                 led_o,
  output ethpipe_pkg::dma_len_t                      dma_length_o,
  output ethpipe_pkg::dma_addr_t                     dma_addr_start_o,
  output logic                                       dma_load_o,
  output ethpipe_pkg::tx_ptr_t                       tx_wr_ptr_o
);
  import ethpipe_pkg::*;

  logic                wr_stb;
  logic                rd_stb;
  logic                load_hit;
  dma_status_t         status;
  dma_status_t         status_rd;
  bus_data_t           cur_shadow;
  bus_data_t           reg_view;
  bus_data_t           wr_word;
  logic [TS_SLOTS-1:0] ts_hit;
  logic [1:0]          ts_word;

  assign wr_stb = slv_ce_i & slv_we_i;
  assign rd_stb = slv_ce_i & ~slv_we_i;

  assign load_hit = (slv_adr_i == ADR_LEN_LO) || (slv_adr_i == ADR_LEN_HI) ||
                    (slv_adr_i == ADR_DMA_START_LO) || (slv_adr_i == ADR_DMA_START_HI);

  // interrupt flag is owned by the moderator
  always_comb begin
    status_rd = status;
    status_rd[STATUS_INTR_BIT] = intr_active_i;
  end

  assign led_o = ~status_rd;

  // --------------------
  // address decode, register view in memory byte order
  always_comb begin
    reg_addr_t off;
    reg_view = '0;
    ts_hit   = '0;
    ts_word  = '0;
    case (slv_adr_i)
      ADR_GCNT0:        reg_view = gcount_i[15:0];
      ADR_GCNT1:        reg_view = gcount_i[31:16];
      ADR_GCNT2:        reg_view = gcount_i[47:32];
      ADR_GCNT3:        reg_view = gcount_i[63:48];
      ADR_STATUS:       reg_view = {8'h00, status_rd};
      ADR_LEN_LO:       reg_view = {dma_length_o[13:0], 2'b00};
      ADR_LEN_HI:       reg_view = {10'h000, dma_length_o[19:14]};
      ADR_DMA_START_LO: reg_view = {dma_addr_start_o[13:0], 2'b00};
      ADR_DMA_START_HI: reg_view = dma_addr_start_o[29:14];
      ADR_DMA_CUR_LO:   reg_view = {dma_addr_cur_i[13:0], 2'b00};
      ADR_DMA_CUR_HI:   reg_view = cur_shadow;
      ADR_TX_WR_PTR:    reg_view = {2'b00, tx_wr_ptr_o};
      ADR_TX_RD_PTR:    reg_view = {2'b00, tx_rd_ptr_i};
      ADR_CLR_VAL_LO:   reg_view = clr_val_o[15:0];
      ADR_CLR_VAL_HI:   reg_view = clr_val_o[31:16];
      ADR_SET_VAL_LO:   reg_view = set_val_o[15:0];
      ADR_SET_VAL_HI:   reg_view = set_val_o[31:16];
      default:          reg_view = '0;
    endcase
    // three words per time-stamp slot
    for (int n = 0; n < TS_SLOTS; n++) begin
      off = slv_adr_i - reg_addr_t'(ADR_TS_BASE + 3 * n);
      if (off < 8'd3) begin
        ts_hit[n] = 1'b1;
        ts_word   = off[1:0];
        reg_view  = ts_i[n][16 * off[1:0] +: 16];
      end
    end
  end

  assign wr_word    = lane_merge(reg_view, slv_dat_i, slv_sel_i);
  assign ts_wr_o    = wr_stb ? ts_hit : '0;
  assign ts_word_o  = ts_word;
  assign intr_ack_o = wr_stb && (slv_adr_i == ADR_STATUS) && slv_sel_i[1] &&
                      !slv_dat_i[STATUS_INTR_BIT];

  // --------------------
  // register writes
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      status           <= '0;
      dma_length_o     <= DMA_LEN_RESET;
      dma_addr_start_o <= DMA_ADDR_RESET;
      tx_wr_ptr_o      <= '0;
      clr_val_o        <= INTR_VAL_RESET;
      set_val_o        <= INTR_VAL_RESET;
      dma_load_o       <= 1'b0;
    end else begin
      dma_load_o <= wr_stb & load_hit;
      if (wr_stb) begin
        case (slv_adr_i)
          ADR_STATUS:       status                  <= wr_word[7:0];
          ADR_LEN_LO:       dma_length_o[13:0]      <= wr_word[15:2];
          ADR_LEN_HI:       dma_length_o[19:14]     <= wr_word[5:0];
          ADR_DMA_START_LO: dma_addr_start_o[13:0]  <= wr_word[15:2];
          ADR_DMA_START_HI: dma_addr_start_o[29:14] <= wr_word;
          ADR_TX_WR_PTR:    tx_wr_ptr_o             <= wr_word[13:0];
          ADR_CLR_VAL_LO:   clr_val_o[15:0]         <= wr_word;
          ADR_CLR_VAL_HI:   clr_val_o[31:16]        <= wr_word;
          ADR_SET_VAL_LO:   set_val_o[15:0]         <= wr_word;
          ADR_SET_VAL_HI:   set_val_o[31:16]        <= wr_word;
          default: ;
        endcase
      end
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk_125) begin
    if (sys_rst)
      slv_dat_o <= '0;
    else if (rd_stb)
      slv_dat_o <= lane_swap(reg_view);
  end

  // high half frozen when the low half is read
  always_ff @(posedge clk_125) begin
    if (rd_stb && (slv_adr_i == ADR_DMA_CUR_LO))
      cur_shadow <= dma_addr_cur_i[29:14];
  end

endmodule

/* logic/ethpipe_ctrl_top.sv */
`timescale 1ns/1ps

module ethpipe_ctrl_top (
  input  logic                             clk_125,
  input  logic                             sys_rst,
  input  logic                             slv_ce_i,
  input  logic                             slv_we_i,
  input  ethpipe_pkg::reg_addr_t           slv_adr_i,
  input  ethpipe_pkg::bus_data_t           slv_dat_i,
  input  ethpipe_pkg::byte_sel_t           slv_sel_i,
  output ethpipe_pkg::bus_data_t           slv_dat_o,
  input  logic                             req_intr_i,
  input  logic [ethpipe_pkg::TS_SLOTS-1:0] time_req_i,
  input  ethpipe_pkg::dma_addr_t           dma_addr_cur_i,
  input  ethpipe_pkg::tx_ptr_t             tx_rd_ptr_i,
  output logic                             sys_intr_o,
  output logic [7:0]                       led_o,
  output ethpipe_pkg::dma_len_t            dma_length_o,
  output ethpipe_pkg::dma_addr_t           dma_addr_start_o,
  output logic                             dma_load_o,
  output ethpipe_pkg::tx_ptr_t             tx_wr_ptr_o
);
  import ethpipe_pkg::*;

  gcount_t                  gcount;
  tstamp_t [TS_SLOTS-1:0]   ts_val;
  logic    [TS_SLOTS-1:0]   ts_wr;
  logic    [1:0]            ts_word;
  logic                     intr_ack;
  intr_cnt_t                clr_val;
  intr_cnt_t                set_val;
  logic                     tmr_load;
  intr_cnt_t                tmr_value;
  logic                     tmr_zero;

  host_regs u_regs (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .slv_ce_i(slv_ce_i), .slv_we_i(slv_we_i), .slv_adr_i(slv_adr_i),
    .slv_dat_i(slv_dat_i), .slv_sel_i(slv_sel_i), .slv_dat_o(slv_dat_o),
    .gcount_i(gcount), .ts_i(ts_val), .intr_active_i(sys_intr_o),
    .dma_addr_cur_i(dma_addr_cur_i), .tx_rd_ptr_i(tx_rd_ptr_i),
    .ts_wr_o(ts_wr), .ts_word_o(ts_word), .intr_ack_o(intr_ack),
    .clr_val_o(clr_val), .set_val_o(set_val), .led_o(led_o),
    .dma_length_o(dma_length_o), .dma_addr_start_o(dma_addr_start_o),
    .dma_load_o(dma_load_o), .tx_wr_ptr_o(tx_wr_ptr_o)
  );

  intr_moderator_fsm u_fsm (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .req_intr_i(req_intr_i), .intr_ack_i(intr_ack), .tmr_zero_i(tmr_zero),
    .clr_val_i(clr_val), .set_val_i(set_val),
    .tmr_load_o(tmr_load), .tmr_value_o(tmr_value), .intr_active_o(sys_intr_o)
  );

  intr_timer u_tmr (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .load_i(tmr_load), .value_i(tmr_value), .zero_o(tmr_zero)
  );

  timestamp_unit u_ts (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .time_req_i(time_req_i), .ts_wr_i(ts_wr), .ts_word_i(ts_word),
    .slv_sel_i(slv_sel_i), .slv_dat_i(slv_dat_i),
    .gcount_o(gcount), .ts_o(ts_val)
  );

endmodule

/* tb/tb_host_bus.svh */
// register shadow in register byte order, indexed by word address
logic [15:0] shadow [256];

function automatic logic [15:0] byte_swap(input logic [15:0] w);
  return {w[7:0], w[15:8]};
endfunction

// implemented bits per word
function automatic logic [15:0] reg_mask(input reg_addr_t adr);
  case (adr)
    ADR_STATUS:                   return 16'h00ff;
    ADR_LEN_LO, ADR_DMA_START_LO: return 16'hfffc;
    ADR_LEN_HI:                   return 16'h003f;
    ADR_TX_WR_PTR:                return 16'h3fff;
    ADR_DMA_START_HI, ADR_CLR_VAL_LO, ADR_CLR_VAL_HI,
    ADR_SET_VAL_LO, ADR_SET_VAL_HI: return 16'hffff;
    default: begin
      if (adr >= ADR_TS_BASE && adr < ADR_TS_BASE + reg_addr_t'(3 * TS_SLOTS))
        return 16'hffff;
      return 16'h0000;
    end
  endcase
endfunction

function automatic void reset_model();
  for (int a = 0; a < 256; a++)
    shadow[a] = '0;
  shadow[ADR_LEN_LO]       = {DMA_LEN_RESET[13:0], 2'b00};
  shadow[ADR_LEN_HI]       = {10'h000, DMA_LEN_RESET[19:14]};
  shadow[ADR_DMA_START_LO] = {DMA_ADDR_RESET[13:0], 2'b00};
  shadow[ADR_DMA_START_HI] = DMA_ADDR_RESET[29:14];
  shadow[ADR_CLR_VAL_LO]   = INTR_VAL_RESET[15:0];
  shadow[ADR_CLR_VAL_HI]   = INTR_VAL_RESET[31:16];
  shadow[ADR_SET_VAL_LO]   = INTR_VAL_RESET[15:0];
  shadow[ADR_SET_VAL_HI]   = INTR_VAL_RESET[31:16];
endfunction

// high bus lane holds byte 2k, low bus lane byte 2k+1
function automatic void model_write(input reg_addr_t adr, input logic [15:0] dat,
                                    input logic [1:0] sel);
  logic [15:0] w;
  w = shadow[adr];
  if (sel[1])
    w[7:0] = dat[15:8];
  if (sel[0])
    w[15:8] = dat[7:0];
  shadow[adr] = w & reg_mask(adr);
endfunction

// expected bus word for a read
function automatic logic [15:0] ref_reg(input reg_addr_t adr, input logic intr);
  logic [15:0] w;
  w = shadow[adr] & reg_mask(adr);
  if (adr == ADR_STATUS)
    w[STATUS_INTR_BIT] = intr;
  return byte_swap(w);
endfunction

task automatic bus_write(input reg_addr_t adr, input logic [15:0] dat, input logic [1:0] sel);
  @(posedge clk_125);
  slv_ce_i  <= 1'b1;
  slv_we_i  <= 1'b1;
  slv_adr_i <= adr;
  slv_dat_i <= dat;
  slv_sel_i <= sel;
  @(posedge clk_125);
  slv_ce_i <= 1'b0;
  slv_we_i <= 1'b0;
  model_write(adr, dat, sel);
endtask

task automatic bus_read(input reg_addr_t adr, output logic [15:0] dat);
  @(posedge clk_125);
  slv_ce_i  <= 1'b1;
  slv_we_i  <= 1'b0;
  slv_adr_i <= adr;
  @(posedge clk_125);
  slv_ce_i <= 1'b0;
  @(negedge clk_125);
  dat = slv_dat_o;
endtask

/* tb/tb_ethpipe_ctrl.sv */
`timescale 1ns/1ps

module tb_ethpipe_ctrl;
  import ethpipe_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int SET_CYC     = 12;
  localparam int CLR_CYC     = 20;
  localparam int TEST_CYCLES = 500 + 2 * SET_CYC + CLR_CYC;

  logic                clk_125 = 1'b0;
  logic                sys_rst;
  logic                slv_ce_i;
  logic                slv_we_i;
  reg_addr_t           slv_adr_i;
  bus_data_t           slv_dat_i;
  byte_sel_t           slv_sel_i;
  bus_data_t           slv_dat_o;
  logic                req_intr_i;
  logic [TS_SLOTS-1:0] time_req_i;
  dma_addr_t           dma_addr_cur_i;
  tx_ptr_t             tx_rd_ptr_i;
  logic                sys_intr_o;
  logic [7:0]          led_o;
  dma_len_t            dma_length_o;
  dma_addr_t           dma_addr_start_o;
  logic                dma_load_o;
  tx_ptr_t             tx_wr_ptr_o;

  reg_addr_t wr_regs [10] = '{ADR_STATUS, ADR_LEN_LO, ADR_LEN_HI, ADR_DMA_START_LO,
                              ADR_DMA_START_HI, ADR_TX_WR_PTR, ADR_CLR_VAL_LO,
                              ADR_CLR_VAL_HI, ADR_SET_VAL_LO, ADR_SET_VAL_HI};
  reg_addr_t unmapped [6] = '{8'h00, 8'h06, 8'h0c, 8'h20, 8'h86, 8'hff};

  // pending checks for the compare process
  string       name_q [$];
  logic [63:0] lo_q [$];
  logic [63:0] hi_q [$];
  logic [63:0] act_q [$];
  event        chk_ev;
  string       cmp_name;
  logic [63:0] cmp_lo;
  logic [63:0] cmp_hi;
  logic [63:0] cmp_act;
  int          load_cnt;

  `include "tb_host_bus.svh"

  ethpipe_ctrl_top u_dut (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .slv_ce_i(slv_ce_i), .slv_we_i(slv_we_i), .slv_adr_i(slv_adr_i),
    .slv_dat_i(slv_dat_i), .slv_sel_i(slv_sel_i), .slv_dat_o(slv_dat_o),
    .req_intr_i(req_intr_i), .time_req_i(time_req_i),
    .dma_addr_cur_i(dma_addr_cur_i), .tx_rd_ptr_i(tx_rd_ptr_i),
    .sys_intr_o(sys_intr_o), .led_o(led_o), .dma_length_o(dma_length_o),
    .dma_addr_start_o(dma_addr_start_o), .dma_load_o(dma_load_o),
    .tx_wr_ptr_o(tx_wr_ptr_o)
  );

  always #(CLK_PERIOD / 2) clk_125 = ~clk_125;

  always @(negedge clk_125) begin
    if (sys_rst)
      load_cnt <= 0;
    else if (dma_load_o)
      load_cnt <= load_cnt + 1;
  end

  task automatic check_range(input string name, input logic [63:0] lo, input logic [63:0] hi,
                             input logic [63:0] act);
    name_q.push_back(name);
    lo_q.push_back(lo);
    hi_q.push_back(hi);
    act_q.push_back(act);
    -> chk_ev;
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_range(name, exp, exp, act);
  endtask

  task automatic read_check(input reg_addr_t adr, input logic intr);
    logic [15:0] rd;
    bus_read(adr, rd);
    check($sformatf("slv_dat_o@%02h", adr), {48'h0, ref_reg(adr, intr)}, {48'h0, rd});
  endtask

  // multi-word value with the lowest word at base
  task automatic read_words(input reg_addr_t base, input int cnt, output logic [63:0] val);
    logic [15:0] w;
    val = '0;
    for (int k = 0; k < cnt; k++) begin
      bus_read(base + reg_addr_t'(k), w);
      val[16 * k +: 16] = byte_swap(w);
    end
  endtask

  task automatic pulse_req();
    @(posedge clk_125);
    req_intr_i <= 1'b1;
    @(posedge clk_125);
    req_intr_i <= 1'b0;
  endtask

  task automatic wait_level(input logic level, input int limit, output int n);
    n = 0;
    do begin
      @(negedge clk_125);
      n++;
    end while (sys_intr_o != level && n < limit);
  endtask

  always @(chk_ev) begin
    while (name_q.size() != 0) begin
      cmp_name = name_q.pop_front();
      cmp_lo   = lo_q.pop_front();
      cmp_hi   = hi_q.pop_front();
      cmp_act  = act_q.pop_front();
      assert (cmp_act >= cmp_lo && cmp_act <= cmp_hi) else begin
        if (cmp_lo == cmp_hi)
          $display("ERR t=%0t %s exp=%0h act=%0h", $time, cmp_name, cmp_lo, cmp_act);
        else
          $display("ERR t=%0t %s exp=%0h..%0h act=%0h", $time, cmp_name, cmp_lo, cmp_hi,
                   cmp_act);
        $display("TEST RESULT: FAIL");
        $fatal(1);
      end
    end
  end

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  initial begin
    logic [15:0] rd;
    logic [15:0] st;
    logic [7:0]  led_exp;
    dma_addr_t   cur;
    tx_ptr_t     ptr;
    logic [63:0] c0;
    logic [63:0] c1;
    logic [63:0] c2;
    logic [63:0] tsv;
    int          n;
    int          n0;
    void'($urandom(32'h973cf18b));
    sys_rst        <= 1'b1;
    slv_ce_i       <= 1'b0;
    slv_we_i       <= 1'b0;
    slv_adr_i      <= '0;
    slv_dat_i      <= '0;
    slv_sel_i      <= '0;
    req_intr_i     <= 1'b0;
    time_req_i     <= '0;
    dma_addr_cur_i <= '0;
    tx_rd_ptr_i    <= '0;
    reset_model();
    repeat (8) @(posedge clk_125);
    sys_rst <= 1'b0;
    @(negedge clk_125);

    // --------------------
    // reset values and random readback
    check("sys_intr_o", 0, sys_intr_o);
    check("dma_load_o", 0, dma_load_o);
    check("led_o", 8'hff, led_o);
    foreach (wr_regs[i])
      read_check(wr_regs[i], 1'b0);
    foreach (unmapped[i])
      read_check(unmapped[i], 1'b0);
    for (int r = 0; r < 4; r++) begin
      foreach (wr_regs[i])
        bus_write(wr_regs[i], 16'($urandom), 2'($urandom));
      foreach (wr_regs[i])
        read_check(wr_regs[i], 1'b0);
    end
    st      = ref_reg(ADR_STATUS, 1'b0);
    led_exp = ~st[15:8];
    check("led_o", led_exp, led_o);

    // --------------------
    // DMA outputs
    n0 = load_cnt;
    for (int i = 0; i < 4; i++) begin
      bus_write(wr_regs[i + 1], 16'($urandom), 2'b11);
      repeat (3) @(posedge clk_125);
      check("dma_load_o pulses", 64'(n0 + i + 1), 64'(load_cnt));
    end
    bus_write(ADR_TX_WR_PTR, 16'($urandom), 2'b11);
    repeat (3) @(posedge clk_125);
    check("dma_load_o pulses", 64'(n0 + 4), 64'(load_cnt));
    check("dma_length_o", {shadow[ADR_LEN_HI][5:0], shadow[ADR_LEN_LO][15:2]}, dma_length_o);
    check("dma_addr_start_o", {shadow[ADR_DMA_START_HI], shadow[ADR_DMA_START_LO][15:2]},
          dma_addr_start_o);
    check("tx_wr_ptr_o", shadow[ADR_TX_WR_PTR][13:0], tx_wr_ptr_o);
    cur = 30'($urandom);
    ptr = 14'($urandom);
    @(posedge clk_125);
    dma_addr_cur_i <= cur;
    tx_rd_ptr_i    <= ptr;
    bus_read(ADR_DMA_CUR_LO, rd);
    check("slv_dat_o cur lo", byte_swap({cur[13:0], 2'b00}), rd);
    @(posedge clk_125);
    dma_addr_cur_i <= ~cur;
    bus_read(ADR_DMA_CUR_HI, rd);
    check("slv_dat_o cur hi", byte_swap(cur[29:14]), rd);
    bus_read(ADR_TX_RD_PTR, rd);
    check("slv_dat_o tx rd ptr", byte_swap({2'b00, ptr}), rd);

    // --------------------
    // interrupt dwell
    bus_write(ADR_SET_VAL_LO, byte_swap(16'(SET_CYC)), 2'b11);
    bus_write(ADR_SET_VAL_HI, 16'h0000, 2'b11);
    bus_write(ADR_CLR_VAL_LO, byte_swap(16'(CLR_CYC)), 2'b11);
    bus_write(ADR_CLR_VAL_HI, 16'h0000, 2'b11);
    pulse_req();
    wait_level(1'b1, 4, n);
    check_range("cycles to sys_intr_o rise", 1, 3, n);
    wait_level(1'b0, SET_CYC + 4, n);
    check_range("sys_intr_o high cycles", SET_CYC, SET_CYC + 2, n);
    read_check(ADR_STATUS, 1'b0);
    st      = ref_reg(ADR_STATUS, 1'b0);
    led_exp = ~st[15:8];
    check("led_o", led_exp, led_o);

    // --------------------
    // holdoff after ack
    pulse_req();
    wait_level(1'b1, 4, n);
    check_range("cycles to sys_intr_o rise", 1, 3, n);
    read_check(ADR_STATUS, 1'b1);
    st      = ref_reg(ADR_STATUS, 1'b1);
    led_exp = ~st[15:8];
    check("led_o", led_exp, led_o);
    bus_write(ADR_STATUS, 16'h0000, 2'b10);
    @(negedge clk_125);
    check("sys_intr_o", 0, sys_intr_o);
    for (int i = 0; i < CLR_CYC - 4; i++) begin
      @(posedge clk_125);
      req_intr_i <= (i % 3 == 0);
      @(negedge clk_125);
      check("sys_intr_o", 0, sys_intr_o);
    end
    @(posedge clk_125);
    req_intr_i <= 1'b0;
    repeat (8) begin
      @(negedge clk_125);
      check("sys_intr_o", 0, sys_intr_o);
    end
    pulse_req();
    wait_level(1'b1, 4, n);
    check_range("cycles to sys_intr_o rise", 1, 3, n);
    wait_level(1'b0, SET_CYC + 4, n);
    check_range("sys_intr_o high cycles", SET_CYC, SET_CYC + 2, n);

    // --------------------
    // time stamps
    read_words(ADR_GCNT0, 4, c0);
    read_words(ADR_GCNT0, 4, c1);
    check_range("gcount increase", c0 + 1, '1, c1);
    @(posedge clk_125);
    time_req_i <= 2'b11;
    @(posedge clk_125);
    time_req_i <= 2'b00;
    repeat (4) @(posedge clk_125);
    for (int s = 0; s < TS_SLOTS; s++) begin
      read_words(ADR_TS_BASE + reg_addr_t'(3 * s), 3, tsv);
      read_words(ADR_GCNT0, 4, c2);
      check_range($sformatf("time stamp slot %0d", s), c1 + 1, c2 - 1, tsv);
    end
    for (int w = 0; w < 3; w++)
      bus_write(ADR_TS_BASE + reg_addr_t'(3 + w), 16'($urandom), 2'b11);
    for (int w = 0; w < 3; w++)
      read_check(ADR_TS_BASE + reg_addr_t'(3 + w), 1'b0);

    repeat (2) @(posedge clk_125);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+tb
logic/ethpipe_pkg.sv
logic/intr_timer.sv
logic/intr_moderator_fsm.sv
logic/timestamp_unit.sv
logic/host_regs.sv
logic/ethpipe_ctrl_top.sv
tb/tb_ethpipe_ctrl.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_ethpipe_ctrl -Mdir obj_dir -f verilog.f

./obj_dir/Vtb_ethpipe_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
